/* design/na_pkg.sv */
// shared types and address map of the tile network adapter
// single clock domain, 16-bit byte addresses, 32-bit data
// region taken from adr[15:12], 0 = config, 1 = message port
// ctlist holds at most max_cts entries, num_cts must not exceed it
package na_pkg;

   localparam int max_cts = 8; // size of the compute tile list

   typedef struct packed {
      logic [31:0] num_tiles;
      logic [31:0] cores_per_tile;
      logic [31:0] gmem_size;
      logic [31:0] gmem_tile;  // tile id holding global memory
      logic [31:0] lmem_size;
      logic [31:0] num_cts;    // valid entries in ctlist
      logic [max_cts-1:0][15:0] ctlist;
   } na_config_t;

   // single-beat request, one per cycle at most
   typedef struct packed {
      logic        cyc;  // request present
      logic        we;   // write
      logic [15:0] adr;  // byte address
      logic [31:0] dat;  // write data
   } bus_req_t;

   // response, one cycle after the request
   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;  // read data
   } bus_rsp_t;

   // network flit, no routing info
   typedef struct packed {
      logic        valid;
      logic        last;  // closes a message
      logic [31:0] data;
   } noc_flit_t;

   typedef enum logic [1:0] {
      region_conf,
      region_mp,
      region_none
   } na_region_e;

   // word index adr[11:2] of the config block
   typedef enum logic [9:0] {
      reg_tileid    = 10'd0,
      reg_numtiles  = 10'd1,
      reg_conf      = 10'd3,
      reg_corebase  = 10'd4,
      reg_cores     = 10'd6,
      reg_gmem_size = 10'd7,
      reg_gmem_tile = 10'd8,
      reg_lmem_size = 10'd9,
      reg_numcts    = 10'd10
   } conf_reg_e;

   localparam logic [15:0] conf_ctlist_base = 16'h0200; // ctlist halfwords from here

   // message port byte offsets
   localparam logic [15:0] mp_send      = 16'h1000; // wr flit, rd credits
   localparam logic [15:0] mp_send_last = 16'h1004; // wr last flit
   localparam logic [15:0] mp_pop       = 16'h1008; // rd pops head data
   localparam logic [15:0] mp_status    = 16'h100c; // rd fill count, head last

endpackage

/* design/na_conf.sv */
// read-only configuration block, purely combinational
// every selected access is acked, writes included, write data is dropped
// unmapped words read 0
// ctlist halfwords from 0x200 up, entry k maps to ctlist[num_cts-1-k]
// num_cts is assumed <= max_cts
module na_conf #(
   parameter na_pkg::na_config_t na_config = '0,
   parameter logic [31:0] tile_id = 32'd0,
   parameter logic [31:0] core_base = 32'd0
) (
   input  logic             conf_sel,
   input  na_pkg::bus_req_t req,
   output na_pkg::bus_rsp_t rsp
);

   localparam int ctw = $clog2(na_pkg::max_cts); // ctlist index width

   // bit positions in the conf word
   localparam int conf_bit_mp  = 0;
   localparam int conf_bit_dma = 1;

   na_pkg::conf_reg_e word;   // word index of the access
   logic              ct_area; // address inside the tile list
   logic [7:0]        ct_idx;  // requested list entry
   logic [31:0]       ct_pos;  // position in the struct, reversed
   logic              ct_hit;
   logic [15:0]       ct_entry;
   logic [31:0]       rd_data;

   assign word    = na_pkg::conf_reg_e'(req.adr[11:2]);
   assign ct_area = req.adr[11:0] >= na_pkg::conf_ctlist_base[11:0];

   // list index, halfword granular
   assign ct_idx = req.adr[8:1];
   assign ct_pos = na_config.num_cts - 32'(ct_idx) - 32'd1; // reverse order
   // entries at or past num_cts read 0
   assign ct_hit = (32'(ct_idx) < na_config.num_cts) &&
                   (ct_pos < 32'(na_pkg::max_cts));
   assign ct_entry = ct_hit ? na_config.ctlist[ct_pos[ctw-1:0]] : 16'h0;

   always_comb begin
      rd_data = 32'h0; // unmapped words
      if (ct_area) begin
         if (req.adr[1]) begin
            rd_data = {16'h0, ct_entry}; // odd halfword, lower half
         end else begin
            rd_data = {ct_entry, 16'h0}; // even halfword, upper half
         end
      end else begin
         case (word)
            na_pkg::reg_tileid: begin
               rd_data = tile_id;
            end
            na_pkg::reg_numtiles: begin
               rd_data = na_config.num_tiles;
            end
            na_pkg::reg_conf: begin
               rd_data[conf_bit_mp]  = 1'b1; // message port present
               rd_data[conf_bit_dma] = 1'b0; // no dma
            end
            na_pkg::reg_corebase: begin
               rd_data = core_base;
            end
            na_pkg::reg_cores: begin
               rd_data = na_config.cores_per_tile;
            end
            na_pkg::reg_gmem_size: begin
               rd_data = na_config.gmem_size;
            end
            na_pkg::reg_gmem_tile: begin
               rd_data = na_config.gmem_tile;
            end
            na_pkg::reg_lmem_size: begin
               rd_data = na_config.lmem_size;
            end
            na_pkg::reg_numcts: begin
               rd_data = na_config.num_cts;
            end
            default: begin
               rd_data = 32'h0;
            end
         endcase
      end
   end

   // answer in the same cycle, mux registers it
   always_comb begin
      rsp     = '0;
      rsp.ack = conf_sel;
      rsp.err = 1'b0;         // never fails
      rsp.dat = rd_data;
   end

endmodule

/* design/na_bus_mux.sv */
// region decode and response register
// targets answer combinationally, the answer is registered for one cycle
// unused regions and message offsets answer err with data 0
module na_bus_mux (
   input  logic             clk,
   input  logic             rst,
   input  na_pkg::bus_req_t req,
   output logic             conf_sel,
   output logic             mp_send_sel,
   output logic             mp_recv_sel,
   input  na_pkg::bus_rsp_t conf_rsp,
   input  na_pkg::bus_rsp_t send_rsp,
   input  na_pkg::bus_rsp_t recv_rsp,
   output na_pkg::bus_rsp_t rsp
);

   na_pkg::na_region_e region;
   logic               send_hit; // offset owned by the send port
   logic               recv_hit; // offset owned by the receive port
   na_pkg::bus_rsp_t   rsp_next;
   na_pkg::bus_rsp_t   rsp_q;

   always_comb begin
      case (req.adr[15:12])
         4'h0:    region = na_pkg::region_conf;
         4'h1:    region = na_pkg::region_mp;
         default: region = na_pkg::region_none;
      endcase
   end

   assign send_hit = (req.adr == na_pkg::mp_send) || (req.adr == na_pkg::mp_send_last);
   assign recv_hit = (req.adr == na_pkg::mp_pop) || (req.adr == na_pkg::mp_status);

   assign conf_sel    = req.cyc && (region == na_pkg::region_conf);
   assign mp_send_sel = req.cyc && (region == na_pkg::region_mp) && send_hit;
   assign mp_recv_sel = req.cyc && (region == na_pkg::region_mp) && recv_hit;

   // pick the answer of the selected target
   always_comb begin
      if (!req.cyc) begin
         rsp_next = '0; // idle, no response
      end else if (conf_sel) begin
         rsp_next = conf_rsp;
      end else if (mp_send_sel) begin
         rsp_next = send_rsp;
      end else if (mp_recv_sel) begin
         rsp_next = recv_rsp;
      end else begin
         rsp_next     = '0;
         rsp_next.err = 1'b1; // region none or bad mp offset
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_q <= '0;
      end else begin
         rsp_q <= rsp_next;
      end
   end

   assign rsp = rsp_q;

endmodule

/* design/na_mp_send.sv */
// egress message port with credit flow control
// write at mp_send / mp_send_last launches a flit, last taken from the offset
// a flit leaves on noc_out one cycle after its write, for one cycle
// zero credits: the write answers err and nothing is sent
// the receiver never returns more credits than send_credits
module na_mp_send #(
   parameter int send_credits = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  na_pkg::bus_req_t  req,
   output na_pkg::bus_rsp_t  rsp,
   output na_pkg::noc_flit_t noc_out,
   input  logic              noc_out_credit
);

   localparam int cw = $clog2(send_credits + 1); // counter width

   logic [cw-1:0] credit_cnt;  // credits held right now
   logic          no_credit;
   logic          wr;
   logic          rd;
   logic          launch;      // flit accepted this cycle
   logic          out_valid_q;
   logic          out_last_q;
   logic [31:0]   out_data_q;

   assign wr        = sel && req.we;
   assign rd        = sel && !req.we;
   assign no_credit = credit_cnt == '0;
   assign launch    = wr && !no_credit;

   // credit counter, a credit in the same cycle as a send cancels out
   always_ff @(posedge clk) begin
      if (rst) begin
         credit_cnt <= cw'(send_credits);
      end else begin
         case ({launch, noc_out_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= launch; // single-cycle valid
      end
   end

   // payload, only loaded on launch
   always_ff @(posedge clk) begin
      if (launch) begin
         out_last_q <= req.adr == na_pkg::mp_send_last;
         out_data_q <= req.dat;
      end
   end

   always_comb begin
      noc_out       = '0;
      noc_out.valid = out_valid_q;
      noc_out.last  = out_last_q;
      noc_out.data  = out_data_q;
   end

   always_comb begin
      rsp     = '0;
      rsp.err = wr && no_credit;     // send refused
      rsp.ack = sel && !(wr && no_credit);
      if (rd) begin
         rsp.dat = 32'(credit_cnt);  // current credits
      end
   end

endmodule

/* design/na_mp_recv.sv */
// ingress message port, circular flit FIFO
// recv_depth must be a power of two, at least 2 and at most 128
// a flit arriving while full is dropped, the sender broke the credit rule
// each pop returns one credit on noc_in_credit in the next cycle
module na_mp_recv #(
   parameter int recv_depth = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  na_pkg::bus_req_t  req,
   output na_pkg::bus_rsp_t  rsp,
   input  na_pkg::noc_flit_t noc_in,
   output logic              noc_in_credit
);

   localparam int aw = $clog2(recv_depth); // pointer width

   logic [32:0]   mem [recv_depth];  // {last, data}
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [aw:0]   fill_cnt;
   logic          empty;
   logic          full;
   logic          push;
   logic          pop;
   logic          status_rd;
   logic          pop_empty; // pop attempt on empty FIFO
   logic          head_last;
   logic [31:0]   head_data;
   logic          credit_q;

   assign empty = fill_cnt == '0;
   assign full  = fill_cnt == (aw+1)'(recv_depth);

   assign push      = noc_in.valid && !full;
   assign pop       = sel && !req.we && (req.adr == na_pkg::mp_pop) && !empty;
   assign pop_empty = sel && !req.we && (req.adr == na_pkg::mp_pop) && empty;
   assign status_rd = sel && !req.we && (req.adr == na_pkg::mp_status);

   assign head_last = !empty && mem[rd_ptr][32]; // 0 when nothing is held
   assign head_data = mem[rd_ptr][31:0];

   // flit storage, no reset
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {noc_in.last, noc_in.data};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fill_cnt <= '0;
         credit_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps, power of two depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   fill_cnt <= fill_cnt + 1'b1;
            2'b01:   fill_cnt <= fill_cnt - 1'b1;
            default: fill_cnt <= fill_cnt;
         endcase
         credit_q <= pop; // one credit per pop
      end
   end

   assign noc_in_credit = credit_q;

   always_comb begin
      rsp     = '0;
      rsp.err = sel && (req.we || pop_empty); // writes and empty pops fail
      rsp.ack = sel && !(req.we || pop_empty);
      if (pop) begin
         rsp.dat = head_data;
      end else if (status_rd) begin
         rsp.dat = {23'h0, head_last, 8'(fill_cnt)};
      end
   end

endmodule

/* design/na_top.sv */
// network adapter register side, single clock
// one request per cycle, response exactly one cycle later
// region 0 config, region 1 message port, others err
module na_top #(
   parameter na_pkg::na_config_t na_config = '0,
   parameter logic [31:0] tile_id = 32'd0,
   parameter logic [31:0] core_base = 32'd0,
   parameter int send_credits = 4,
   parameter int recv_depth = 4   // power of two
) (
   input  logic              clk,
   input  logic              rst,
   input  na_pkg::bus_req_t  req,
   output na_pkg::bus_rsp_t  rsp,
   output na_pkg::noc_flit_t noc_out,
   input  logic              noc_out_credit,
   input  na_pkg::noc_flit_t noc_in,
   output logic              noc_in_credit
);

   logic             conf_sel;
   logic             mp_send_sel;
   logic             mp_recv_sel;
   na_pkg::bus_rsp_t conf_rsp;
   na_pkg::bus_rsp_t send_rsp;
   na_pkg::bus_rsp_t recv_rsp;

   na_bus_mux u_mux (
      .clk(clk), .rst(rst), .req(req),
      .conf_sel(conf_sel), .mp_send_sel(mp_send_sel), .mp_recv_sel(mp_recv_sel),
      .conf_rsp(conf_rsp), .send_rsp(send_rsp), .recv_rsp(recv_rsp),
      .rsp(rsp)
   );

   na_conf #(.na_config(na_config), .tile_id(tile_id), .core_base(core_base)) u_conf (
      .conf_sel(conf_sel), .req(req), .rsp(conf_rsp)
   );

   na_mp_send #(.send_credits(send_credits)) u_send (
      .clk(clk), .rst(rst), .sel(mp_send_sel), .req(req), .rsp(send_rsp),
      .noc_out(noc_out), .noc_out_credit(noc_out_credit)
   );

   na_mp_recv #(.recv_depth(recv_depth)) u_recv (
      .clk(clk), .rst(rst), .sel(mp_recv_sel), .req(req), .rsp(recv_rsp),
      .noc_in(noc_in), .noc_in_credit(noc_in_credit)
   );

endmodule

/* tb/na_assertions.sv */
// bus response timing and credit rules of na_top, attached with bind
// recv_full is taken from inside the receive port
// send credits are tracked from the link, starting at send_credits
module na_assertions #(
   parameter int send_credits = 4
) (
   input logic              clk,
   input logic              rst,
   input na_pkg::bus_req_t  req,
   input na_pkg::bus_rsp_t  rsp,
   input na_pkg::noc_flit_t noc_out,
   input logic              noc_out_credit,
   input na_pkg::noc_flit_t noc_in,
   input logic              recv_full
);
   timeunit 1ns;
   timeprecision 1ps;

   int credit_left; // room the network still has for our flits

   // flits seen on the link take a credit, pulses give one back
   always_ff @(posedge clk) begin
      if (rst) begin
         credit_left <= send_credits;
      end else begin
         credit_left <= credit_left - int'(noc_out.valid) + int'(noc_out_credit);
      end
   end

   ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(rsp.ack && rsp.err))
      else $error("ack and err high together");

   // exactly one cycle per request
   rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
      req.cyc |=> (rsp.ack || rsp.err))
      else $error("no response one cycle after a request");

   no_stray_rsp: assert property (@(posedge clk) disable iff (rst)
      !req.cyc |=> !(rsp.ack || rsp.err))
      else $error("response without a request");

   // flit launched the cycle before, the link must still have had room
   send_needs_credit: assert property (@(posedge clk) disable iff (rst)
      noc_out.valid |-> credit_left > 0)
      else $error("flit sent with zero credits");

   no_push_when_full: assert property (@(posedge clk) disable iff (rst)
      noc_in.valid |-> !recv_full)
      else $error("flit arrived on noc_in while the FIFO was full");

endmodule

/* tb/na_tb.sv */
// testbench for na_top with a model of both network links
// send_credits 4, recv_depth 4, five compute tiles in the config record
// flits and credits are driven only from the main thread, so the model stays exact
module na_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_credits = 4;
   localparam int rx_depth = 4;
   localparam int rsp_timeout = 10;   // cycles per bus access
   localparam logic [31:0] tile_no = 32'd7;
   localparam logic [31:0] core_first = 32'd28;
   localparam na_pkg::na_config_t cfg = '{
      num_tiles: 32'd16, cores_per_tile: 32'd4, gmem_size: 32'h0100_0000,
      gmem_tile: 32'd3, lmem_size: 32'h0001_0000, num_cts: 32'd5,
      ctlist: {16'h0, 16'h0, 16'h0, 16'h000c, 16'h0009, 16'h0006, 16'h0003, 16'h0001}};

   typedef struct packed {
      na_pkg::bus_rsp_t rsp;
      logic             rd;    // data compared on reads only
      logic [15:0]      adr;
   } pending_t;

   logic              clk;
   logic              rst;
   logic              noc_out_credit;
   logic              noc_in_credit;
   na_pkg::bus_req_t  req;
   na_pkg::bus_rsp_t  rsp;
   na_pkg::noc_flit_t noc_out;
   na_pkg::noc_flit_t noc_in;

   pending_t    pend_q[$];          // responses still owed
   logic [32:0] flit_q[$];          // {last, data} the adapter should send
   logic [32:0] rx_q[$];            // flits held in the adapter FIFO
   int          credits = n_credits; // adapter send credits, reference view
   int          granted = n_credits; // credits handed out by the network
   int          rx_credits = rx_depth;
   int          exp_pulses = 0;
   int          in_pulses = 0;
   int          errors = 0;
   int          checks = 0;
   pending_t    cur;
   logic [32:0] cur_flit;

   na_top #(.na_config(cfg), .tile_id(tile_no), .core_base(core_first),
            .send_credits(n_credits), .recv_depth(rx_depth)) UUT (
      .clk(clk), .rst(rst), .req(req), .rsp(rsp),
      .noc_out(noc_out), .noc_out_credit(noc_out_credit),
      .noc_in(noc_in), .noc_in_credit(noc_in_credit)
   );

   bind na_top na_assertions #(.send_credits(send_credits)) u_assert (
      .clk(clk), .rst(rst), .req(req), .rsp(rsp), .noc_out(noc_out),
      .noc_out_credit(noc_out_credit), .noc_in(noc_in), .recv_full(u_recv.full)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // config word from the record, tile list halfwords from 0x200
   function automatic logic [31:0] conf_word(input logic [15:0] adr);
      logic [15:0] half;
      int unsigned k;
      k = adr[8:1];
      half = (k < cfg.num_cts) ? cfg.ctlist[cfg.num_cts - 1 - k] : 16'h0; // reversed
      if (adr[11:0] >= 12'h200) return adr[1] ? {16'h0, half} : {half, 16'h0};
      case (adr[11:2])
         na_pkg::reg_tileid:    return tile_no;
         na_pkg::reg_numtiles:  return cfg.num_tiles;
         na_pkg::reg_conf:      return 32'h1;   // message port only
         na_pkg::reg_corebase:  return core_first;
         na_pkg::reg_cores:     return cfg.cores_per_tile;
         na_pkg::reg_gmem_size: return cfg.gmem_size;
         na_pkg::reg_gmem_tile: return cfg.gmem_tile;
         na_pkg::reg_lmem_size: return cfg.lmem_size;
         na_pkg::reg_numcts:    return cfg.num_cts;
         default:               return 32'h0;
      endcase
   endfunction

   // expected response from the address map and the link models
   function automatic na_pkg::bus_rsp_t ref_rsp(input logic we, input logic [15:0] adr);
      na_pkg::bus_rsp_t r;
      logic             send_adr;
      r = '0;
      r.err = 1'b1;   // anything not decoded below
      send_adr = (adr == na_pkg::mp_send) || (adr == na_pkg::mp_send_last);
      if (adr[15:12] == 4'h0) begin
         r.err = 1'b0;
         r.dat = conf_word(adr);
      end else if (send_adr && !we) begin
         r.err = 1'b0;
         r.dat = 32'(credits);
      end else if (send_adr) begin
         r.err = (credits == 0);
      end else if (adr == na_pkg::mp_pop && !we) begin
         r.err = (rx_q.size() == 0);
         r.dat = r.err ? 32'h0 : rx_q[0][31:0];
      end else if (adr == na_pkg::mp_status && !we) begin
         r.err = 1'b0;
         r.dat = {23'h0, (rx_q.size() > 0) ? rx_q[0][32] : 1'b0, 8'(rx_q.size())};
      end
      r.ack = !r.err;
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("%0d errors in %0d checks", errors + 1, checks);
      $display("Test FAILED");
      $finish;
   endtask

   // one request, model updated up front, waits for the response
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat);
      pending_t p;
      int       waited;
      p.rsp = ref_rsp(we, adr);
      p.rd  = !we;
      p.adr = adr;
      pend_q.push_back(p);
      if (we && p.rsp.ack && adr[15:12] == 4'h1) begin   // accepted send
         flit_q.push_back({adr == na_pkg::mp_send_last, dat});
         credits--;
      end
      if (!we && p.rsp.ack && adr == na_pkg::mp_pop) begin
         void'(rx_q.pop_front());
         exp_pulses++;
      end
      @(posedge clk);
      req <= '{cyc: 1'b1, we: we, adr: adr, dat: dat};
      @(posedge clk);
      req <= '0;
      waited = 0;
      @(negedge clk);
      while (!(rsp.ack || rsp.err) && waited < rsp_timeout) begin
         waited++;
         @(negedge clk);
      end
      if (!(rsp.ack || rsp.err)) abort_run("bus response never arrived");
   endtask

   task automatic return_credit();
      @(posedge clk);
      noc_out_credit <= 1'b1;
      @(posedge clk);
      noc_out_credit <= 1'b0;
      credits++;   // counted by the adapter from here on
      granted++;
   endtask

   task automatic inject_flit(input logic last, input logic [31:0] data);
      @(posedge clk);
      noc_in <= '{valid: 1'b1, last: last, data: data};
      @(posedge clk);
      noc_in <= '0;
      rx_q.push_back({last, data});
      rx_credits--;
   endtask

   // compare every bus response with the oldest expected one
   always @(negedge clk) begin
      if (!rst && (rsp.ack || rsp.err)) begin
         if (pend_q.size() == 0) begin
            errors++;
            $display("ERROR: bus response with no request pending");
         end else begin
            cur = pend_q.pop_front();
            checks++;
            if ({rsp.ack, rsp.err} !== {cur.rsp.ack, cur.rsp.err}) begin
               errors++;
               $display("FAILED rsp.ack/err adr %h: got %h, expected %h", cur.adr,
                        {rsp.ack, rsp.err}, {cur.rsp.ack, cur.rsp.err});
            end
            if (cur.rd && rsp.dat !== cur.rsp.dat) begin
               errors++;
               $display("FAILED rsp.dat adr %h: got %h, expected %h", cur.adr, rsp.dat,
                        cur.rsp.dat);
            end
         end
      end
   end

   // network side, outgoing flits against granted credits, credit pulses back
   always @(negedge clk) begin
      if (!rst && noc_out.valid) begin
         checks++;
         if (granted == 0) begin
            errors++;
            $display("ERROR: flit left the adapter with no credit granted");
         end else begin
            granted--;
         end
         if (flit_q.size() == 0) begin
            errors++;
            $display("ERROR: flit on noc_out that was never accepted");
         end else begin
            cur_flit = flit_q.pop_front();
            if ({noc_out.last, noc_out.data} !== cur_flit) begin
               errors++;
               $display("FAILED noc_out {last,data}: got %h, expected %h",
                        {noc_out.last, noc_out.data}, cur_flit);
            end
         end
      end
      if (!rst && noc_in_credit) begin
         in_pulses++;
         rx_credits++;   // sender may inject again
      end
   end

   initial begin
      void'($urandom(64));
      req = '0;
      noc_in = '0;
      noc_out_credit = 1'b0;
      rst = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // config words, mapped and unmapped, then every list halfword
      for (int i = 0; i < 24; i++) bus_access(1'b0, 16'(4 * i), 32'h0);
      for (int i = 0; i < 16; i++) bus_access(1'b0, 16'h0200 + 16'(2 * i), 32'h0);
      bus_access(1'b1, 16'h0004, $urandom);   // acked, data dropped
      bus_access(1'b1, 16'h0202, $urandom);
      bus_access(1'b0, 16'h0004, 32'h0);

      // unmapped regions and message offsets
      for (int r = 2; r < 16; r++) bus_access(1'($urandom), {4'(r), 12'($urandom)}, $urandom);
      bus_access(1'b0, 16'h1010, 32'h0);
      bus_access(1'b1, 16'h1ffc, 32'h0);
      bus_access(1'b0, 16'h1002, 32'h0);
      bus_access(1'b1, na_pkg::mp_pop, 32'h0);
      bus_access(1'b1, na_pkg::mp_status, 32'h0);

      // sends with credits coming back in random order
      for (int i = 0; i < 12; i++) begin
         if (credits > 0) begin
            bus_access(1'b1, ($urandom_range(2, 0) == 0) ? na_pkg::mp_send_last :
                       na_pkg::mp_send, $urandom);
         end
         if (credits < n_credits && $urandom_range(1, 0) == 1) return_credit();
         bus_access(1'b0, na_pkg::mp_send, 32'h0);
      end

      // out of credits, refused, then one credit back
      while (credits > 0) bus_access(1'b1, na_pkg::mp_send, $urandom);
      bus_access(1'b1, na_pkg::mp_send_last, $urandom);
      bus_access(1'b0, na_pkg::mp_send, 32'h0);
      return_credit();
      bus_access(1'b1, na_pkg::mp_send_last, $urandom);
      while (credits < n_credits) return_credit();
      bus_access(1'b0, na_pkg::mp_send, 32'h0);

      // fill the receive FIFO, drain it, then mixed traffic
      for (int i = 0; i < rx_depth; i++) begin
         inject_flit(1'($urandom), $urandom);
         bus_access(1'b0, na_pkg::mp_status, 32'h0);
      end
      repeat (rx_depth) begin
         bus_access(1'b0, na_pkg::mp_pop, 32'h0);
         bus_access(1'b0, na_pkg::mp_status, 32'h0);
      end
      bus_access(1'b0, na_pkg::mp_pop, 32'h0);   // empty
      for (int i = 0; i < 16; i++) begin
         if (rx_credits > 0 && $urandom_range(1, 0) == 1) inject_flit(1'($urandom), $urandom);
         else bus_access(1'b0, na_pkg::mp_pop, 32'h0);
         bus_access(1'b0, na_pkg::mp_status, 32'h0);
      end
      while (rx_q.size() > 0) bus_access(1'b0, na_pkg::mp_pop, 32'h0);

      repeat (2) @(posedge clk);
      if (in_pulses != exp_pulses) begin
         errors++;
         $display("FAILED noc_in_credit pulses: got %h, expected %h", in_pulses, exp_pulses);
      end
      if (flit_q.size() != 0) begin
         errors++;
         $display("ERROR: %0d accepted flits never left the adapter", flit_q.size());
      end
      if (pend_q.size() != 0) begin
         errors++;
         $display("ERROR: %0d bus responses never arrived", pend_q.size());
      end
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0) $display("Test OK");
      else $display("Test FAILED");
      $finish;
   end

endmodule

/* compile.f */
design/na_pkg.sv
design/na_conf.sv
design/na_bus_mux.sv
design/na_mp_send.sv
design/na_mp_recv.sv
design/na_top.sv
tb/na_assertions.sv
tb/na_tb.sv

/* Bender.yml */
package:
  name: na_tile_adapter

sources:
  - design/na_pkg.sv
  - design/na_conf.sv
  - design/na_bus_mux.sv
  - design/na_mp_send.sv
  - design/na_mp_recv.sv
  - design/na_top.sv
  - target: test
    files:
      - tb/na_assertions.sv
      - tb/na_tb.sv
